// File: flist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_redirect_if.sv
verilog/fetch_pc_unit.sv
verilog/fetch_addr_gen.sv
verilog/fetch_resp_track.sv
verilog/fetch_iq.sv
verilog/fetch_top.sv
tb/imem_model.sv
tb/fetch_tb.sv

// File: tb/fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage testbench
// Table driven loads, consumes, stalls and flushes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_params.svh"

module fetch_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT  = 200;
   localparam int MAX_ROWS = 8;

   logic                clk;
   logic                rst_n_i;
   logic                flush_i;
   logic                load_i;
   fetch_pkg::addr_t    load_address_i;
   logic [15:0]         cs_register_i;
   fetch_pkg::addr_t    eip_o;
   logic                set_eip_o;
   logic                imem_valid_o;
   logic                imem_ready_i;
   fetch_pkg::addr_t    imem_address_o;
   logic                imem_dp_valid_i;
   logic                imem_dp_ready_o;
   fetch_pkg::line_t    imem_dp_read_data_i;
   logic                f_valid_o;
   logic                f_ready_i;
   fetch_pkg::consume_t f_bytes_read_i;
   fetch_pkg::count_t   f_valid_bytes_o;
   fetch_pkg::window_t  f_instruction_o;
   fetch_pkg::addr_t    f_pc_o;

   // Stimulus table, consume sizes one per byte with the first in the low byte
   fetch_pkg::addr_t    row_addr [MAX_ROWS];
   logic [15:0]         row_cs [MAX_ROWS];
   logic [63:0]         row_cons [MAX_ROWS];
   logic                row_flush [MAX_ROWS];
   logic                row_stall [MAX_ROWS];
   int                  n_rows;

   fetch_pkg::addr_t    exp_pc;

   fetch_top dut (
      .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i), .load_i(load_i),
      .load_address_i(load_address_i), .cs_register_i(cs_register_i),
      .eip_o(eip_o), .set_eip_o(set_eip_o),
      .imem_valid_o(imem_valid_o), .imem_ready_i(imem_ready_i),
      .imem_address_o(imem_address_o), .imem_dp_valid_i(imem_dp_valid_i),
      .imem_dp_ready_o(imem_dp_ready_o), .imem_dp_read_data_i(imem_dp_read_data_i),
      .f_valid_o(f_valid_o), .f_ready_i(f_ready_i), .f_bytes_read_i(f_bytes_read_i),
      .f_valid_bytes_o(f_valid_bytes_o), .f_instruction_o(f_instruction_o),
      .f_pc_o(f_pc_o)
   );

   imem_model u_imem (
      .clk(clk), .rst_n_i(rst_n_i),
      .imem_valid_i(imem_valid_o), .imem_ready_o(imem_ready_i),
      .imem_address_i(imem_address_o), .imem_dp_valid_o(imem_dp_valid_i),
      .imem_dp_ready_i(imem_dp_ready_o), .imem_dp_data_o(imem_dp_read_data_i)
   );

   always #4 clk = ~clk;

   task automatic add_row(input fetch_pkg::addr_t addr, input logic [15:0] cs,
                          input logic [63:0] cons, input logic flush, input logic stall);
      row_addr[n_rows]  = addr;
      row_cs[n_rows]    = cs;
      row_cons[n_rows]  = cons;
      row_flush[n_rows] = flush;
      row_stall[n_rows] = stall;
      n_rows++;
   endtask

   task automatic stop_run();
      $display("Test failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_addr(input string name, input fetch_pkg::addr_t exp,
                             input fetch_pkg::addr_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_window(input string name, input fetch_pkg::window_t exp,
                               input fetch_pkg::window_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input fetch_pkg::count_t exp,
                              input fetch_pkg::count_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
         stop_run();
      end
   endtask

   // Memory content at a byte address
   function automatic logic [7:0] expected_byte(input fetch_pkg::addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
   endfunction

   // Next falling edge, then check the valid part of the window against memory
   task automatic step_cycle();
      fetch_pkg::window_t exp_win;
      fetch_pkg::window_t mask;
      fetch_pkg::addr_t   exp_line;
      @(negedge clk);
      if (f_valid_o) begin
         if (f_valid_bytes_o > fetch_pkg::count_t'(`FETCH_WIN_BYTES)) begin
            $display("Valid byte count %0d is above the window size at %0t",
                     f_valid_bytes_o, $time);
            stop_run();
         end
         exp_win = '0;
         mask    = '0;
         for (int i = 0; i < `FETCH_WIN_BYTES; i++) begin
            if (i < int'(f_valid_bytes_o)) begin
               exp_win[i * 8 +: 8] = expected_byte(exp_pc + fetch_pkg::addr_t'(i));
               mask[i * 8 +: 8]    = 8'hff;
            end
         end
         check_addr("f_pc_o", exp_pc, f_pc_o);
         check_window("f_instruction_o", exp_win, f_instruction_o & mask);
      end
      if (imem_valid_o) begin
         // Next request is for the line after the queued bytes
         exp_line = (exp_pc + fetch_pkg::addr_t'(f_valid_bytes_o)) &
                    ~fetch_pkg::addr_t'(`FETCH_LINE_BYTES - 1);
         check_addr("imem_address_o", exp_line, imem_address_o);
      end
   endtask

   task automatic load_fetch(input fetch_pkg::addr_t addr, input logic [15:0] cs);
      load_i         = 1'b1;
      load_address_i = addr;
      cs_register_i  = cs;
      #1;
      check_flag("set_eip_o", 1'b1, set_eip_o);
      check_addr("eip_o", addr - fetch_pkg::addr_t'(cs), eip_o);
      exp_pc = addr;
      step_cycle();
      load_i = 1'b0;
   endtask

   task automatic wait_valid();
      int t;
      t = 0;
      while (!f_valid_o && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (!f_valid_o) begin
         $display("Timed out waiting for the first valid window at %0t", $time);
         stop_run();
      end
   endtask

   task automatic wait_fill(input fetch_pkg::count_t fill);
      int t;
      t = 0;
      while (f_valid_bytes_o != fill && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (f_valid_bytes_o != fill) begin
         $display("Timed out waiting for the queue to fill to %0d bytes", fill);
         stop_run();
      end
   endtask

   // Advances first, since imem_valid_o follows the load input combinationally
   task automatic wait_request();
      int t;
      t = 0;
      do begin
         step_cycle();
         t++;
      end while (!imem_valid_o && t < TIMEOUT);
      if (!imem_valid_o) begin
         $display("Timed out waiting for a memory request at %0t", $time);
         stop_run();
      end
   endtask

   task automatic consume_bytes(input fetch_pkg::consume_t size);
      int t;
      t = 0;
      while (!(f_valid_o && f_valid_bytes_o >= fetch_pkg::count_t'(size)) && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (!(f_valid_o && f_valid_bytes_o >= fetch_pkg::count_t'(size))) begin
         $display("Timed out waiting for %0d bytes to consume", size);
         stop_run();
      end
      f_ready_i      = 1'b1;
      f_bytes_read_i = size;
      exp_pc         = exp_pc + fetch_pkg::addr_t'(size);
      step_cycle();
      f_ready_i      = 1'b0;
      f_bytes_read_i = '0;
   endtask

   // Stale load, flush with its request in flight, then a halted stretch
   task automatic inject_flush(input int r);
      load_fetch(row_addr[r] ^ 32'h0000_0a00, row_cs[r]);
      wait_request();
      step_cycle();
      flush_i = 1'b1;
      step_cycle();
      check_flag("f_valid_o", 1'b0, f_valid_o);
      step_cycle();
      flush_i = 1'b0;
      for (int k = 0; k < 2; k++) begin
         step_cycle();
         check_flag("imem_valid_o", 1'b0, imem_valid_o);
         check_flag("f_valid_o", 1'b0, f_valid_o);
      end
   endtask

   task automatic apply_row(input int r);
      fetch_pkg::count_t fill;
      if (row_flush[r]) begin
         inject_flush(r);
      end
      load_fetch(row_addr[r], row_cs[r]);
      wait_valid();
      check_addr("f_pc_o", row_addr[r], f_pc_o);
      if (row_stall[r]) begin
         // Two lines fit, less the bytes below the target
         fill = fetch_pkg::count_t'(`FETCH_WIN_BYTES) - fetch_pkg::count_t'(row_addr[r][3:0]);
         wait_fill(fill);
         for (int k = 0; k < 6; k++) begin
            step_cycle();
            check_count("f_valid_bytes_o", fill, f_valid_bytes_o);
            check_flag("imem_valid_o", 1'b0, imem_valid_o);
            check_flag("imem_dp_ready_o", 1'b0, imem_dp_ready_o);
         end
      end
      for (int k = 0; k < 8; k++) begin
         consume_bytes(row_cons[r][k * 8 +: 6]);
      end
   endtask

   initial begin
      clk            = 1'b0;
      rst_n_i        = 1'b0;
      flush_i        = 1'b0;
      load_i         = 1'b0;
      load_address_i = '0;
      cs_register_i  = '0;
      f_ready_i      = 1'b0;
      f_bytes_read_i = '0;
      exp_pc         = '0;
      n_rows         = 0;

      //      address       cs        consumes                flush stall
      add_row(32'h0000_1000, 16'h0100, 64'h04_07_01_06_02_08_05_03, 1'b0, 1'b0);
      add_row(32'h0000_2345, 16'h0020, 64'h0d_06_04_0b_09_02_0f_01, 1'b0, 1'b0);
      add_row(32'h0000_3ff8, 16'h0300, 64'h0a_03_0c_05_0e_07_02_09, 1'b0, 1'b1);
      add_row(32'h0000_5003, 16'h0010, 64'h02_0f_03_08_01_0c_06_05, 1'b1, 1'b0);
      add_row(32'h0000_7000, 16'h0000, 64'h0f_0f_0f_0f_0f_0f_0f_0f, 1'b0, 1'b1);
      add_row(32'h0000_8ffe, 16'hffff, 64'h01_02_03_04_05_06_07_08, 1'b1, 1'b1);

      repeat (4) @(negedge clk);
      rst_n_i = 1'b1;

      // Idle until the first load
      for (int k = 0; k < 6; k++) begin
         step_cycle();
         check_flag("imem_valid_o", 1'b0, imem_valid_o);
         check_flag("f_valid_o", 1'b0, f_valid_o);
         check_flag("set_eip_o", 1'b0, set_eip_o);
      end

      for (int r = 0; r < n_rows; r++) begin
         apply_row(r);
      end

      $display("Test passed");
      $finish;
   end

endmodule

// File: tb/imem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory model
// Random latency line responder, byte pattern taken from the address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module imem_model (
   input  logic             clk,
   input  logic             rst_n_i,
   input  logic             imem_valid_i,
   output logic             imem_ready_o,
   input  fetch_pkg::addr_t imem_address_i,
   output logic             imem_dp_valid_o,
   input  logic             imem_dp_ready_i,
   output fetch_pkg::line_t imem_dp_data_o
);
   timeunit 1ns;
   timeprecision 1ps;

   integer           seed;
   integer           draw;
   logic             busy;
   logic [1:0]       wait_cnt;
   fetch_pkg::addr_t req_addr;

   // All four address bytes folded together
   function automatic logic [7:0] byte_at(input fetch_pkg::addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
   endfunction

   // Lowest addressed word sits at the top of the bus
   function automatic fetch_pkg::line_t pack_line(input fetch_pkg::addr_t base);
      fetch_pkg::line_t d;
      d = '0;
      for (int w = 0; w < 4; w++) begin
         for (int j = 0; j < 4; j++) begin
            d[(3 - w) * 32 + j * 8 +: 8] = byte_at(base + fetch_pkg::addr_t'(w * 4 + j));
         end
      end
      return d;
   endfunction

   initial begin
      seed            = 30670;
      busy            = 1'b0;
      imem_ready_o    = 1'b0;
      imem_dp_valid_o = 1'b0;
      imem_dp_data_o  = '0;
   end

   // One request at a time, answered 1 to 4 cycles after it is taken
   always @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy     <= 1'b0;
         wait_cnt <= 2'd0;
         req_addr <= '0;
      end else begin
         if (imem_dp_valid_o && imem_dp_ready_i) begin
            busy <= 1'b0;
         end
         if (imem_valid_i && imem_ready_o) begin
            draw     = $random(seed);
            busy     <= 1'b1;
            req_addr <= imem_address_i;
            wait_cnt <= draw[1:0];
         end else if (busy && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

   // Outputs change on the falling edge
   always @(negedge clk) begin
      imem_ready_o    <= rst_n_i & ~busy;
      imem_dp_valid_o <= busy & (wait_cnt == 2'd0);
      imem_dp_data_o  <= (busy && wait_cnt == 2'd0) ? pack_line(req_addr) : '0;
   end

endmodule

// File: verilog/fetch_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch address generator
// Next line address and imem request control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_params.svh"

module fetch_addr_gen (
   input  logic                     clk,
   input  logic                     rst_n_i,
   fetch_redirect_if.consumer       redir,

   // Queue has room and nothing is in flight
   input  logic                     space_ok_i,

   // Instruction memory request
   output logic                     imem_valid_o,
   input  logic                     imem_ready_i,
   output fetch_pkg::addr_t         imem_address_o
);

   localparam fetch_pkg::addr_t LINE_STEP = fetch_pkg::addr_t'(`FETCH_LINE_BYTES);
   localparam fetch_pkg::addr_t LINE_MASK = fetch_pkg::addr_t'(`FETCH_LINE_BYTES - 1);

   logic             armed_q;
   logic             req_accept;
   fetch_pkg::addr_t line_q;

   // No request in a kill cycle, the held line is stale
   assign imem_valid_o   = armed_q & space_ok_i & ~redir.kill;
   assign imem_address_o = line_q;
   assign req_accept     = imem_valid_o & imem_ready_i;

   // Fetch runs from a load until the next flush
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         armed_q <= 1'b0;
      end else if (redir.redirect) begin
         armed_q <= 1'b1;
      end else if (redir.flush) begin
         armed_q <= 1'b0;
      end
   end

   // Line address, aligned on load then stepped per accepted request
   always_ff @(posedge clk) begin
      if (redir.redirect) begin
         line_q <= redir.target & ~LINE_MASK;
      end else if (req_accept) begin
         line_q <= line_q + LINE_STEP;
      end
   end

endmodule

// File: verilog/fetch_iq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch instruction queue
// 32-byte shifting buffer, byte-granular consume
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_params.svh"

module fetch_iq (
   input  logic                     clk,
   input  logic                     rst_n_i,
   fetch_redirect_if.consumer       redir,

   // Line from the response tracker
   input  logic                     line_valid_i,
   input  fetch_pkg::line_t         line_data_i,
   output logic                     line_ready_o,

   // Request gating
   input  logic                     outstanding_i,
   output logic                     space_ok_o,

   // Decode window
   output logic                     f_valid_o,
   input  logic                     f_ready_i,
   input  fetch_pkg::consume_t      f_bytes_read_i,
   output fetch_pkg::count_t        f_valid_bytes_o,
   output fetch_pkg::window_t       f_instruction_o
);

   localparam int OFS_W = $clog2(`FETCH_LINE_BYTES);
   localparam fetch_pkg::count_t LINE_CNT = fetch_pkg::count_t'(`FETCH_LINE_BYTES);
   localparam fetch_pkg::count_t FREE_MAX =
      fetch_pkg::count_t'(`FETCH_WIN_BYTES - `FETCH_LINE_BYTES);

   fetch_pkg::window_t  buf_q;
   fetch_pkg::window_t  buf_n;
   fetch_pkg::window_t  kept;
   fetch_pkg::window_t  incoming;
   fetch_pkg::window_t  keep_mask;
   fetch_pkg::line_t    line_al;
   fetch_pkg::count_t   count_q;
   fetch_pkg::count_t   count_n;
   fetch_pkg::count_t   remain;
   fetch_pkg::count_t   add_cnt;
   fetch_pkg::consume_t take;
   logic [OFS_W-1:0]    skip_q;
   logic [OFS_W-1:0]    drop;
   logic                first_q;
   logic                consume;
   logic                append;

   assign f_valid_o       = (count_q != '0);
   assign f_valid_bytes_o = count_q;
   assign f_instruction_o = buf_q;
   assign consume         = f_valid_o & f_ready_i;

   // Room for one full line
   assign line_ready_o = (count_q <= FREE_MAX);
   assign append       = line_valid_i & line_ready_o;

   // At most one line in flight, so room now covers the pending one
   assign space_ok_o = ~outstanding_i & line_ready_o;

   always_comb begin
      take    = consume ? f_bytes_read_i : '0;
      remain  = count_q - fetch_pkg::count_t'(take);
      drop    = first_q ? skip_q : '0;
      add_cnt = LINE_CNT - fetch_pkg::count_t'(drop);

      // Shift out the consumed bytes
      kept = buf_q >> {take, 3'b000};

      // First line after a load starts at the target byte
      line_al = line_data_i >> {drop, 3'b000};

      // Bytes above the remaining count are cleared before the merge
      keep_mask = ~({$bits(fetch_pkg::window_t){1'b1}} << {remain, 3'b000});
      incoming  = fetch_pkg::window_t'(line_al) << {remain, 3'b000};

      if (append) begin
         buf_n   = (kept & keep_mask) | incoming;
         count_n = remain + add_cnt;
      end else begin
         buf_n   = kept;
         count_n = remain;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
         first_q <= 1'b0;
         skip_q  <= '0;
      end else if (redir.kill) begin
         count_q <= '0;
         first_q <= redir.redirect;
         if (redir.redirect) begin
            skip_q <= redir.target[OFS_W-1:0];
         end
      end else begin
         count_q <= count_n;
         if (append) begin
            first_q <= 1'b0;
         end
      end
   end

   // Byte storage, qualified by count_q
   always_ff @(posedge clk) begin
      buf_q <= buf_n;
   end

endmodule

// File: verilog/fetch_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage sizing macros
// Address, memory line and decode window widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Linear address / EIP width
`define FETCH_ADDR_W 32

// One instruction memory line
`define FETCH_LINE_W 128
`define FETCH_LINE_BYTES 16

// Decode window seen by the decoder
`define FETCH_WIN_BYTES 32

`endif

// File: verilog/fetch_pc_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch PC unit
// EIP from load address and CS, decode PC tracking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_pc_unit (
   input  logic                     clk,
   input  logic                     rst_n_i,

   // Control
   input  logic                     load_i,
   input  logic                     flush_i,
   input  fetch_pkg::addr_t         load_address_i,
   input  logic [15:0]              cs_register_i,

   // Decoder consume
   input  logic                     consume_i,
   input  fetch_pkg::consume_t      bytes_read_i,

   // Outputs
   output fetch_pkg::addr_t         eip_o,
   output logic                     set_eip_o,
   output fetch_pkg::addr_t         f_pc_o,
   fetch_redirect_if.producer       redir
);

   fetch_pkg::addr_t pc_q;

   // EIP is the linear address less the code segment base
   assign eip_o     = load_address_i - fetch_pkg::addr_t'(cs_register_i);
   assign set_eip_o = load_i;

   // Redirect bundle
   assign redir.redirect = load_i;
   assign redir.target   = load_address_i;
   assign redir.flush    = flush_i;
   assign redir.kill     = load_i | flush_i;

   // Decode PC follows the head of the queue
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q <= '0;
      end else if (load_i) begin
         pc_q <= load_address_i;
      end else if (consume_i) begin
         pc_q <= pc_q + fetch_pkg::addr_t'(bytes_read_i);
      end
   end

   assign f_pc_o = pc_q;

endmodule

// File: verilog/fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage types
// Shared data types and the response tracker FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fetch_params.svh"

package fetch_pkg;

   // Linear address or EIP
   typedef logic [`FETCH_ADDR_W-1:0] addr_t;

   // One memory line
   typedef logic [`FETCH_LINE_W-1:0] line_t;

   // Decode window, byte 0 in the low bits
   typedef logic [`FETCH_WIN_BYTES*8-1:0] window_t;

   // Valid bytes in the window, 0 to 32
   typedef logic [6:0] count_t;

   // Bytes taken by the decoder in one consume
   typedef logic [5:0] consume_t;

   // Response tracker states
   typedef enum logic [1:0] {
      RESP_IDLE = 2'd0,
      RESP_WAIT = 2'd1,
      RESP_DROP = 2'd2
   } resp_state_e;

endpackage

// File: verilog/fetch_redirect_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Redirect bundle
// Load and flush events fanned out to the fetch blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface fetch_redirect_if;

   // Load pulse and its linear address
   logic             redirect;
   fetch_pkg::addr_t target;

   // Flush level
   logic             flush;

   // Either event, discards fetch state
   logic             kill;

   modport producer (
      output redirect, target, flush, kill
   );

   modport consumer (
      input redirect, target, flush, kill
   );

endinterface

// File: verilog/fetch_resp_track.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch response tracker
// Outstanding/drop state and word order correction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_resp_track (
   input  logic                     clk,
   input  logic                     rst_n_i,
   fetch_redirect_if.consumer       redir,

   // Request side
   input  logic                     req_accept_i,

   // Instruction memory response
   input  logic                     imem_dp_valid_i,
   input  fetch_pkg::line_t         imem_dp_data_i,
   output logic                     imem_dp_ready_o,

   // Line to the queue
   input  logic                     line_ready_i,
   output logic                     line_valid_o,
   output fetch_pkg::line_t         line_data_o,

   output logic                     outstanding_o
);

   fetch_pkg::resp_state_e state_q, state_n;
   logic                   dp_accept;

   // Memory is accepted whenever the queue has room for a line
   assign imem_dp_ready_o = line_ready_i;
   assign dp_accept       = imem_dp_valid_i & line_ready_i;
   assign outstanding_o   = (state_q != fetch_pkg::RESP_IDLE);

   // Only a live response reaches the queue
   assign line_valid_o = imem_dp_valid_i &
                         (state_q == fetch_pkg::RESP_WAIT) &
                         ~redir.kill;

   // Lowest addressed word ends up in bits 31:0
   assign line_data_o = {imem_dp_data_i[31:0],
                         imem_dp_data_i[63:32],
                         imem_dp_data_i[95:64],
                         imem_dp_data_i[127:96]};

   always_comb begin
      state_n = state_q;
      case (state_q)
         fetch_pkg::RESP_IDLE: begin
            if (req_accept_i) begin
               state_n = fetch_pkg::RESP_WAIT;
            end
         end
         fetch_pkg::RESP_WAIT: begin
            // A response arriving with the kill is swallowed here
            if (dp_accept) begin
               state_n = fetch_pkg::RESP_IDLE;
            end else if (redir.kill) begin
               state_n = fetch_pkg::RESP_DROP;
            end
         end
         fetch_pkg::RESP_DROP: begin
            if (dp_accept) begin
               state_n = fetch_pkg::RESP_IDLE;
            end
         end
         default: begin
            state_n = fetch_pkg::RESP_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= fetch_pkg::RESP_IDLE;
      end else begin
         state_q <= state_n;
      end
   end

endmodule

// File: verilog/fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage top
// Connects PC, address, response and queue blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_top (
   input  logic                     clk,
   input  logic                     rst_n_i,

   // Control
   input  logic                     flush_i,
   input  logic                     load_i,
   input  fetch_pkg::addr_t         load_address_i,
   input  logic [15:0]              cs_register_i,

   // EIP
   output fetch_pkg::addr_t         eip_o,
   output logic                     set_eip_o,

   // Instruction memory
   output logic                     imem_valid_o,
   input  logic                     imem_ready_i,
   output fetch_pkg::addr_t         imem_address_o,
   input  logic                     imem_dp_valid_i,
   output logic                     imem_dp_ready_o,
   input  fetch_pkg::line_t         imem_dp_read_data_i,

   // Decoder
   output logic                     f_valid_o,
   input  logic                     f_ready_i,
   input  fetch_pkg::consume_t      f_bytes_read_i,
   output fetch_pkg::count_t        f_valid_bytes_o,
   output fetch_pkg::window_t       f_instruction_o,
   output fetch_pkg::addr_t         f_pc_o
);

   fetch_redirect_if redir_if ();

   logic             f_consume;
   logic             req_accept;
   logic             space_ok;
   logic             outstanding;
   logic             line_valid;
   logic             line_ready;
   fetch_pkg::line_t line_data;

   assign f_consume  = f_valid_o & f_ready_i;
   assign req_accept = imem_valid_o & imem_ready_i;

   fetch_pc_unit u_pc (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .load_i         (load_i),
      .flush_i        (flush_i),
      .load_address_i (load_address_i),
      .cs_register_i  (cs_register_i),
      .consume_i      (f_consume),
      .bytes_read_i   (f_bytes_read_i),
      .eip_o          (eip_o),
      .set_eip_o      (set_eip_o),
      .f_pc_o         (f_pc_o),
      .redir          (redir_if.producer)
   );

   fetch_addr_gen u_ag (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .redir          (redir_if.consumer),
      .space_ok_i     (space_ok),
      .imem_valid_o   (imem_valid_o),
      .imem_ready_i   (imem_ready_i),
      .imem_address_o (imem_address_o)
   );

   fetch_resp_track u_rt (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .redir           (redir_if.consumer),
      .req_accept_i    (req_accept),
      .imem_dp_valid_i (imem_dp_valid_i),
      .imem_dp_data_i  (imem_dp_read_data_i),
      .line_ready_i    (line_ready),
      .imem_dp_ready_o (imem_dp_ready_o),
      .line_valid_o    (line_valid),
      .line_data_o     (line_data),
      .outstanding_o   (outstanding)
   );

   fetch_iq u_iq (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .redir           (redir_if.consumer),
      .line_valid_i    (line_valid),
      .line_data_i     (line_data),
      .line_ready_o    (line_ready),
      .outstanding_i   (outstanding),
      .space_ok_o      (space_ok),
      .f_valid_o       (f_valid_o),
      .f_ready_i       (f_ready_i),
      .f_bytes_read_i  (f_bytes_read_i),
      .f_valid_bytes_o (f_valid_bytes_o),
      .f_instruction_o (f_instruction_o)
   );

endmodule
